/* Bender.yml */
package:
  name: resp_recv

sources:
  - include_dirs:
      - source
    files:
      - source/rrc_pkg.sv
      - source/cxt_bus_if.sv
      - source/resp_recv_fetch.sv
      - source/cxt_write_port.sv
      - source/cxt_arbiter.sv
      - source/cxt_table.sv
      - source/resp_recv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clkgen.sv
      - dv/tb_checker.sv
      - dv/tb_resp_recv.sv

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import rrc_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      meta_req,
    input  wire net_meta_t meta,
    input  wire logic      slow,
    output logic           meta_ack,
    output int             checked_cnt,
    output int             mismatch_cnt,
    output int             fault_cnt,
    output int             pending_cnt
);

    localparam int TMO = 200;

    // Expected records and their test names, in send order
    net_meta_t exp_q [$];
    string     name_q [$];
    integer    seed;

    // Filled from the testbench top, one entry per header sent
    task automatic expect_record(input string name, input net_meta_t rec);
        exp_q.push_back(rec);
        name_q.push_back(name);
        pending_cnt = exp_q.size();
    endtask

    // Cycles before meta_ack, long in slow mode
    function automatic int ack_delay();
        int unsigned r;
        r = $unsigned($random(seed));
        if (slow) begin
            return 10 + (r % 16);
        end
        return r % 3;
    endfunction

    task automatic compare_record();
        net_meta_t exp;
        string     name;
        if (exp_q.size() == 0) begin
            $display("ERROR: extra record arrived with nothing expected, qpn %h psn %h",
                     meta.local_qpn, meta.psn);
            fault_cnt++;
        end else begin
            exp = exp_q.pop_front();
            name = name_q.pop_front();
            pending_cnt = exp_q.size();
            checked_cnt++;
            if (meta !== exp) begin
                $display("MISMATCH %s expected %h actual %h", name, exp, meta);
                mismatch_cnt++;
            end
        end
    endtask

    // Downstream side of the metadata four-phase
    initial begin
        int n;
        int d;
        seed = 57272;
        meta_ack = 1'b0;
        checked_cnt = 0;
        mismatch_cnt = 0;
        fault_cnt = 0;
        pending_cnt = 0;
        forever begin
            @(posedge clk);
            // New record, req up with ack still low
            if (!rst && meta_req && !meta_ack) begin
                compare_record();
                d = ack_delay();
                repeat (d) @(negedge clk);
                @(negedge clk);
                meta_ack = 1'b1;
                n = 0;
                while (meta_req && n < TMO) begin
                    @(negedge clk);
                    n++;
                end
                if (meta_req) begin
                    $display("ERROR: meta_req stayed high after meta_ack was raised");
                    fault_cnt++;
                end
                meta_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset over the first cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_resp_recv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rrc_macros.svh"

module tb_resp_recv import rrc_pkg::*; ();

    localparam int TMO = 400;

    logic                  clk;
    logic                  rst;
    logic                  pkt_req;
    logic                  pkt_ack;
    pkt_head_t             pkt_head;
    logic                  host_req;
    logic                  host_ack;
    logic [`RRC_QPN_W-1:0] host_qpn;
    qp_cxt_t               host_cxt;
    logic                  meta_req;
    logic                  meta_ack;
    net_meta_t             meta;
    logic                  slow;
    int                    checked_cnt;
    int                    mismatch_cnt;
    int                    fault_cnt;
    int                    pending_cnt;
    int                    other_errors;
    logic                  aborted;
    integer                seed;

    // Shadow of the context table, updated once a host write completes
    qp_cxt_t shadow [`RRC_QP_NUM];

    tb_clkgen i_clkgen (
        .clk (clk),
        .rst (rst)
    );

    resp_recv_top i_resp_recv_top (
        .clk      (clk),
        .rst      (rst),
        .pkt_req  (pkt_req),
        .pkt_ack  (pkt_ack),
        .pkt_head (pkt_head),
        .host_req (host_req),
        .host_ack (host_ack),
        .host_qpn (host_qpn),
        .host_cxt (host_cxt),
        .meta_req (meta_req),
        .meta_ack (meta_ack),
        .meta     (meta)
    );

    tb_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .meta_req     (meta_req),
        .meta         (meta),
        .slow         (slow),
        .meta_ack     (meta_ack),
        .checked_cnt  (checked_cnt),
        .mismatch_cnt (mismatch_cnt),
        .fault_cnt    (fault_cnt),
        .pending_cnt  (pending_cnt)
    );

    // Reference record for one header
    function automatic net_meta_t expected_meta(input pkt_head_t h);
        qp_cxt_t   c;
        net_meta_t m;
        // Only the low QPN bits select the context
        c = shadow[h.local_qpn[`RRC_QPN_W-1:0]];
        m.local_qpn  = h.local_qpn;
        m.opcode     = h.opcode;
        m.psn        = h.psn;
        m.length     = h.length;
        m.remote_qpn = c.remote_qpn;
        m.psn_ok     = c.valid && (h.psn == c.expected_psn);
        return m;
    endfunction

    // Random upper QPN bits, opcode and length
    function automatic pkt_head_t make_head(input logic [`RRC_QPN_W-1:0] idx,
                                            input logic [`RRC_PSN_W-1:0] psn);
        pkt_head_t h;
        h.local_qpn = $random(seed);
        h.local_qpn[`RRC_QPN_W-1:0] = idx;
        h.opcode = $random(seed);
        h.psn = psn;
        h.length = $random(seed);
        return h;
    endfunction

    function automatic qp_cxt_t make_cxt();
        qp_cxt_t c;
        c.valid = 1'b1;
        c.expected_psn = $random(seed);
        c.remote_qpn = $random(seed);
        return c;
    endfunction

    // QP 1..3, PSN matching about half the time
    function automatic pkt_head_t pick_head();
        logic [`RRC_QPN_W-1:0] idx;
        logic [`RRC_PSN_W-1:0] psn;
        idx = 1 + ($unsigned($random(seed)) % 3);
        psn = shadow[idx].expected_psn;
        if ($random(seed) & 1) begin
            psn = psn ^ 24'h000010;
        end
        return make_head(idx, psn);
    endfunction

    task automatic report_stuck(input string msg);
        $display("ERROR: %s", msg);
        other_errors++;
        aborted = 1'b1;
    endtask

    // One full host write, shadow updated only after host_ack falls
    task automatic host_write(input logic [`RRC_QPN_W-1:0] idx, input qp_cxt_t cxt);
        int n;
        if (aborted) return;
        @(negedge clk);
        host_qpn = idx;
        host_cxt = cxt;
        host_req = 1'b1;
        n = 0;
        while (!host_ack && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!host_ack) begin
            report_stuck("host_ack never rose for a host write");
        end
        host_req = 1'b0;
        n = 0;
        while (host_ack && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (host_ack) begin
            report_stuck("host_ack never fell after host_req dropped");
        end
        shadow[idx] = cxt;
    endtask

    // Header four-phase, expected record queued first
    task automatic send_pkt(input string name, input pkt_head_t h);
        int n;
        if (aborted) return;
        i_checker.expect_record(name, expected_meta(h));
        @(negedge clk);
        pkt_head = h;
        pkt_req = 1'b1;
        n = 0;
        while (!pkt_ack && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!pkt_ack) begin
            report_stuck("pkt_ack never rose for a header");
        end else if (meta_req) begin
            $display("ERROR: %s header taken while meta_req was still high", name);
            other_errors++;
        end
        pkt_req = 1'b0;
        n = 0;
        while (pkt_ack && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (pkt_ack) begin
            report_stuck("pkt_ack never fell after pkt_req dropped");
        end
    endtask

    initial begin
        pkt_head_t h;
        qp_cxt_t   c;
        int        n;
        int        total;
        seed = 57272;
        pkt_req = 1'b0;
        pkt_head = '0;
        host_req = 1'b0;
        host_qpn = '0;
        host_cxt = '0;
        slow = 1'b0;
        other_errors = 0;
        aborted = 1'b0;
        for (int i = 0; i < `RRC_QP_NUM; i++) begin
            shadow[i] = '0;
        end
        n = 0;
        while (rst !== 1'b0 && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            report_stuck("reset was never released");
        end

        // Cleared context after reset
        // PSN equals the cleared expected PSN, only valid keeps psn_ok low
        send_pkt("unwritten_qp", make_head(4'd5, 24'd0));

        // Written context, then matching and off-by-one PSN
        c = make_cxt();
        host_write(4'd2, c);
        send_pkt("psn_match", make_head(4'd2, c.expected_psn));
        send_pkt("psn_mismatch", make_head(4'd2, c.expected_psn + 24'd1));

        // Host writes to QP 8..11 racing packets on QP 1..3
        host_write(4'd1, make_cxt());
        host_write(4'd3, make_cxt());
        fork
            begin
                for (int i = 8; i < 12; i++) begin
                    host_write(i[3:0], make_cxt());
                end
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    send_pkt("concurrent", pick_head());
                end
            end
        join

        // Contexts written during the race read back intact
        for (int i = 8; i < 12; i++) begin
            send_pkt("concurrent_wr", make_head(i[3:0], shadow[i].expected_psn));
        end

        // Slow downstream, headers back to back
        slow = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_pkt("backpressure", pick_head());
        end
        slow = 1'b0;

        // Same low bits, different upper QPN bits
        c = make_cxt();
        host_write(4'd7, c);
        h = make_head(4'd7, c.expected_psn);
        h.local_qpn = {20'hABCDE, 4'h7};
        send_pkt("qpn_alias", h);
        h.local_qpn = {20'h00001, 4'h7};
        send_pkt("qpn_alias", h);
        h.local_qpn = {20'h00000, 4'h7};
        send_pkt("qpn_alias", h);

        // Drain the last records
        n = 0;
        while ((pending_cnt != 0 || meta_req || meta_ack) && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (pending_cnt != 0) begin
            $display("ERROR: %0d expected records never arrived", pending_cnt);
            other_errors++;
        end

        total = mismatch_cnt + fault_cnt + other_errors;
        $display("checked=%0d mismatches=%0d faults=%0d other=%0d",
                 checked_cnt, mismatch_cnt, fault_cnt, other_errors);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/rrc_pkg.sv
source/cxt_bus_if.sv
source/resp_recv_fetch.sv
source/cxt_write_port.sv
source/cxt_arbiter.sv
source/cxt_table.sv
source/resp_recv_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_resp_recv.sv

/* source/cxt_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cxt_arbiter (
    input  wire logic    clk,
    input  wire logic    rst,
    cxt_bus_if.arbiter   m0,
    cxt_bus_if.arbiter   m1,
    cxt_bus_if.requester mem
);

    // Transfer in progress, grant locked
    logic busy;
    // Granted requester, 1 selects m1
    logic grant;
    // Requester with first claim next time, 0 selects m0
    logic prio;
    logic mem_req;
    logic win;
    logic sel_req;

    // Round-robin pick
    always_comb begin
        if (!prio) begin
            win = m0.req ? 1'b0 : 1'b1;
        end else begin
            win = m1.req ? 1'b1 : 1'b0;
        end
    end

    assign sel_req = grant ? m1.req : m0.req;

    // Granted requester steers the table side
    assign mem.req      = mem_req;
    assign mem.is_write = grant ? m1.is_write : m0.is_write;
    assign mem.cmd      = grant ? m1.cmd : m0.cmd;

    // Ack routed to the owner only
    assign m0.ack   = busy && !grant && mem.ack;
    assign m1.ack   = busy && grant && mem.ack;
    assign m0.rdata = mem.rdata;
    assign m1.rdata = mem.rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            grant   <= 1'b0;
            prio    <= 1'b0;
            mem_req <= 1'b0;
        end else if (!busy) begin
            if (m0.req || m1.req) begin
                busy    <= 1'b1;
                grant   <= win;
                // Winner drops to lowest priority
                prio    <= !win;
                mem_req <= 1'b1;
            end
        end else if (!mem_req && !mem.ack) begin
            // Downstream ack has fallen, free the grant
            busy <= 1'b0;
        end else begin
            mem_req <= sel_req;
        end
    end

    // Grant locked across the whole transfer
    a_grant_lock: assert property (
        @(posedge clk) disable iff (rst)
        mem.req |=> !mem.req || $stable(grant)
    );

endmodule

`default_nettype wire

/* source/cxt_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One requester's path into the context table
// Four-phase handshake, cmd held stable while req is high
interface cxt_bus_if import rrc_pkg::*; ();

    // Request level from the requester
    logic     req;
    // Ack level back from the arbiter or table
    logic     ack;
    // Selects the write view of cmd
    logic     is_write;
    // Index, plus context for writes
    cxt_cmd_u cmd;
    // Read result, valid while ack is high
    qp_cxt_t  rdata;

    // Side that starts a transfer
    modport requester (
        output req,
        output is_write,
        output cmd,
        input  ack,
        input  rdata
    );

    // Side that serves a transfer
    modport arbiter (
        input  req,
        input  is_write,
        input  cmd,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

/* source/cxt_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rrc_macros.svh"

module cxt_table import rrc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    cxt_bus_if.arbiter port
);

    qp_cxt_t cxt_mem [`RRC_QP_NUM];
    logic    ack_q;
    qp_cxt_t rdata_q;

    // First cycle of a request, act exactly once
    logic    start;

    assign start = port.req && !ack_q;

    assign port.ack   = ack_q;
    assign port.rdata = rdata_q;

    // Ack follows req one cycle later in both directions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= port.req;
        end
    end

    // Contexts cleared at reset, valid low until written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RRC_QP_NUM; i++) begin
                cxt_mem[i] <= '0;
            end
        end else if (start && port.is_write) begin
            cxt_mem[port.cmd.wr.idx] <= port.cmd.wr.cxt;
        end
    end

    // Read data lands with the ack
    always_ff @(posedge clk) begin
        if (start && !port.is_write) begin
            rdata_q <= cxt_mem[port.cmd.rd.idx];
        end
    end

endmodule

`default_nettype wire

/* source/cxt_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rrc_macros.svh"

module cxt_write_port import rrc_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   host_req,
    output logic                        host_ack,
    input  wire logic [`RRC_QPN_W-1:0]  host_qpn,
    input  wire qp_cxt_t                host_cxt,
    cxt_bus_if.requester                bus
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_WRITE,
        W_DRAIN,
        W_HOLD
    } state_t;

    state_t                state;
    logic                  wr_req;
    logic [`RRC_QPN_W-1:0] qpn_q;
    qp_cxt_t               cxt_q;
    cxt_cmd_u              wr_cmd;

    // Write view of the command word
    always_comb begin
        wr_cmd        = '0;
        wr_cmd.wr.idx = qpn_q;
        wr_cmd.wr.cxt = cxt_q;
    end

    assign bus.req      = wr_req;
    assign bus.is_write = 1'b1;
    assign bus.cmd      = wr_cmd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= W_IDLE;
            wr_req   <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (host_req) begin
                        wr_req <= 1'b1;
                        state  <= W_WRITE;
                    end
                end
                // Table has stored the context once ack comes back
                W_WRITE: begin
                    if (bus.ack) begin
                        wr_req <= 1'b0;
                        state  <= W_DRAIN;
                    end
                end
                // Close the bus handshake before telling the host
                W_DRAIN: begin
                    if (!bus.ack) begin
                        host_ack <= 1'b1;
                        state    <= W_HOLD;
                    end
                end
                W_HOLD: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Host write captured at request
    always_ff @(posedge clk) begin
        if (state == W_IDLE && host_req) begin
            qpn_q <= host_qpn;
            cxt_q <= host_cxt;
        end
    end

endmodule

`default_nettype wire

/* source/resp_recv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rrc_macros.svh"

module resp_recv_fetch import rrc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       pkt_req,
    output logic            pkt_ack,
    input  wire pkt_head_t  pkt_head,
    cxt_bus_if.requester    bus,
    output logic            meta_req,
    input  wire logic       meta_ack,
    output net_meta_t       meta
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        RELEASE,
        EMIT,
        DONE
    } state_t;

    state_t    state;
    logic      cxt_req;
    pkt_head_t head_q;
    net_meta_t meta_q;
    cxt_cmd_u  rd_cmd;

    // New header taken only with both handshakes idle
    logic      take_pkt;

    assign take_pkt = (state == IDLE) && pkt_req && !pkt_ack;

    // Read command, table index from the low QPN bits
    always_comb begin
        rd_cmd        = '0;
        rd_cmd.rd.idx = head_q.local_qpn[`RRC_QPN_W-1:0];
        rd_cmd.rd.pad = '0;
    end

    assign bus.req      = cxt_req;
    assign bus.is_write = 1'b0;
    assign bus.cmd      = rd_cmd;

    assign meta = meta_q;

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pkt_ack  <= 1'b0;
            cxt_req  <= 1'b0;
            meta_req <= 1'b0;
        end else begin
            // Packet side closes its own four-phase
            if (pkt_ack && !pkt_req) begin
                pkt_ack <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (take_pkt) begin
                        pkt_ack <= 1'b1;
                        cxt_req <= 1'b1;
                        state   <= FETCH;
                    end
                end
                // Wait for context, then drop req
                FETCH: begin
                    if (bus.ack) begin
                        cxt_req <= 1'b0;
                        state   <= RELEASE;
                    end
                end
                // Bus must be idle before emitting
                RELEASE: begin
                    if (!bus.ack) begin
                        meta_req <= 1'b1;
                        state    <= EMIT;
                    end
                end
                EMIT: begin
                    if (meta_ack) begin
                        meta_req <= 1'b0;
                        state    <= DONE;
                    end
                end
                // Downstream ack low, ready for next header
                DONE: begin
                    if (!meta_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Header capture and metadata build
    always_ff @(posedge clk) begin
        if (take_pkt) begin
            head_q <= pkt_head;
        end
        if (state == FETCH && bus.ack) begin
            meta_q.local_qpn  <= head_q.local_qpn;
            meta_q.opcode     <= head_q.opcode;
            meta_q.psn        <= head_q.psn;
            meta_q.length     <= head_q.length;
            meta_q.remote_qpn <= bus.rdata.remote_qpn;
            // PSN match only counts for a written context
            meta_q.psn_ok     <= bus.rdata.valid && (head_q.psn == bus.rdata.expected_psn);
        end
    end

    // Record held until downstream takes it
    a_meta_stable: assert property (
        @(posedge clk) disable iff (rst)
        meta_req && !meta_ack |=> $stable(meta)
    );

    // Back-pressure, no new header while output busy
    a_pkt_stall: assert property (
        @(posedge clk) disable iff (rst)
        $rose(pkt_ack) |-> !$past(meta_req) && !$past(meta_ack)
    );

endmodule

`default_nettype wire

/* source/resp_recv_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rrc_macros.svh"

module resp_recv_top import rrc_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // Packet headers from the parser
    input  wire logic                   pkt_req,
    output logic                        pkt_ack,
    input  wire pkt_head_t              pkt_head,
    // Host context writes
    input  wire logic                   host_req,
    output logic                        host_ack,
    input  wire logic [`RRC_QPN_W-1:0]  host_qpn,
    input  wire qp_cxt_t                host_cxt,
    // Net metadata downstream
    output logic                        meta_req,
    input  wire logic                   meta_ack,
    output net_meta_t                   meta
);

    // Fetch side, write side, and the table link
    cxt_bus_if fetch_bus ();
    cxt_bus_if wr_bus ();
    cxt_bus_if mem_bus ();

    resp_recv_fetch i_fetch (
        .clk      (clk),
        .rst      (rst),
        .pkt_req  (pkt_req),
        .pkt_ack  (pkt_ack),
        .pkt_head (pkt_head),
        .bus      (fetch_bus.requester),
        .meta_req (meta_req),
        .meta_ack (meta_ack),
        .meta     (meta)
    );

    cxt_write_port i_write_port (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_ack (host_ack),
        .host_qpn (host_qpn),
        .host_cxt (host_cxt),
        .bus      (wr_bus.requester)
    );

    // Fetch on m0 so it has first claim after reset
    cxt_arbiter i_arbiter (
        .clk (clk),
        .rst (rst),
        .m0  (fetch_bus.arbiter),
        .m1  (wr_bus.arbiter),
        .mem (mem_bus.requester)
    );

    cxt_table i_table (
        .clk  (clk),
        .rst  (rst),
        .port (mem_bus.arbiter)
    );

endmodule

`default_nettype wire

/* source/rrc_macros.svh */
`ifndef RRC_MACROS_SVH
`define RRC_MACROS_SVH

// Context table sizing

// Index bits taken from the low end of the local QPN
`define RRC_QPN_W 4

// Number of queue-pair contexts held in the table
`define RRC_QP_NUM 16

// Full wire width of a QPN field
// Local and remote QPN both use it
`define RRC_QPN_FULL_W 24

// Packet header field widths

// Packet sequence number, also the expected PSN in the context
`define RRC_PSN_W 24

// Message length in bytes
`define RRC_LEN_W 16

// Transport opcode as carried by the parser
`define RRC_OPC_W 5

`endif

/* source/rrc_pkg.sv */
`default_nettype none

`include "rrc_macros.svh"

package rrc_pkg;

    // Parser word, one per packet, 69 bits
    typedef struct packed {
        logic [`RRC_QPN_FULL_W-1:0] local_qpn;
        logic [`RRC_OPC_W-1:0]      opcode;
        logic [`RRC_PSN_W-1:0]      psn;
        logic [`RRC_LEN_W-1:0]      length;
    } pkt_head_t;

    // Per-QP context record, 49 bits
    // Valid clear means never written since reset
    typedef struct packed {
        logic                       valid;
        logic [`RRC_PSN_W-1:0]      expected_psn;
        logic [`RRC_QPN_FULL_W-1:0] remote_qpn;
    } qp_cxt_t;

    // Read view of a context command
    // Index on top, rest is padding
    typedef struct packed {
        logic [`RRC_QPN_W-1:0]      idx;
        logic [$bits(qp_cxt_t)-1:0] pad;
    } cxt_rd_cmd_t;

    // Write view, index plus the new context
    typedef struct packed {
        logic [`RRC_QPN_W-1:0] idx;
        qp_cxt_t               cxt;
    } cxt_wr_cmd_t;

    // Context bus command word, 53 bits
    // is_write on the bus picks the view
    typedef union packed {
        cxt_rd_cmd_t rd;
        cxt_wr_cmd_t wr;
    } cxt_cmd_u;

    // Record handed downstream, 94 bits
    typedef struct packed {
        logic [`RRC_QPN_FULL_W-1:0] local_qpn;
        logic [`RRC_OPC_W-1:0]      opcode;
        logic [`RRC_PSN_W-1:0]      psn;
        logic [`RRC_LEN_W-1:0]      length;
        logic [`RRC_QPN_FULL_W-1:0] remote_qpn;
        logic                       psn_ok;
    } net_meta_t;

endpackage

`default_nettype wire
